/* Makefile */
TOP       ?= tb_core
SEED      ?= 13
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Gstart_seed=$(SEED) \
		--Mdir $(OBJ_DIR)

run: build
	@$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clock,
    output logic reset
);
    // 100 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #50;
            clock = ~clock;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core #(
    parameter int start_seed = 13
);
    import core_pkg::*;

    logic        clock;
    logic        reset;
    logic        test_reset;
    logic        core_reset;
    logic        ibus_cyc;
    logic        ibus_stb;
    logic [63:0] ibus_adr;
    logic        ibus_ack;
    logic [31:0] ibus_dat;
    logic        wb_valid;
    logic [4:0]  wb_regnum;
    logic [63:0] wb_data;
    logic        reserved_inst;
    logic [63:0] reserved_pc;

    logic [31:0] imem [0:1023];
    logic [68:0] exp_writes [$];
    logic [63:0] exp_reserved [$];
    logic [68:0] expected;
    logic [63:0] expected_pc;
    logic        counting;
    int          at;
    int          seed = start_seed;
    int          max_wait;
    int          wait_left;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          commits = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;

    tb_clock clock_gen (
        .clock(clock),
        .reset(reset)
    );

    assign core_reset = reset || test_reset;

    core_top u_core_top (
        .clock        (clock),
        .reset        (core_reset),
        .ibus_cyc     (ibus_cyc),
        .ibus_stb     (ibus_stb),
        .ibus_adr     (ibus_adr),
        .ibus_ack     (ibus_ack),
        .ibus_dat     (ibus_dat),
        .wb_valid     (wb_valid),
        .wb_regnum    (wb_regnum),
        .wb_data      (wb_data),
        .reserved_inst(reserved_inst),
        .reserved_pc  (reserved_pc)
    );

    // wishbone slave acks after wait_left extra cycles and drops ack after one edge
    always @(posedge clock) begin
        #1;
        if (core_reset || ibus_ack) begin
            ibus_ack = 1'b0;
            counting = 1'b0;
        end else if (ibus_cyc && ibus_stb) begin
            if (!counting) begin
                counting = 1'b1;
                wait_left = (max_wait == 0) ? 0 : int'($unsigned($random(seed)) % (max_wait + 1));
            end
            if (wait_left == 0) begin
                ibus_ack = 1'b1;
                ibus_dat = imem[ibus_adr[11:2]];
            end else begin
                wait_left--;
            end
        end
    end

    always @(negedge clock) begin
        if (!core_reset && wb_valid) begin
            commits++;
            if (exp_writes.size() == 0) begin
                $display("commit to r%0d at %0t was not expected by the model", wb_regnum, $time);
                errors++;
            end else begin
                expected = exp_writes.pop_front();
                checks++;
                assert (wb_regnum == expected[68:64] && wb_data == expected[63:0])
                else begin
                    $display("** Error at %0t: r%0d expected %h, got r%0d = %h", $time,
                             expected[68:64], expected[63:0], wb_regnum, wb_data);
                    errors++;
                end
            end
        end
        if (!core_reset && reserved_inst) begin
            if (exp_reserved.size() == 0) begin
                $display("reserved_inst at %0t for pc %h was not expected", $time, reserved_pc);
                errors++;
            end else begin
                expected_pc = exp_reserved.pop_front();
                checks++;
                assert (reserved_pc == expected_pc)
                else begin
                    $display("** Error at %0t: reserved_pc expected %h, got %h", $time,
                             expected_pc, reserved_pc);
                    errors++;
                end
            end
        end
    end

    initial begin
        wait (cycle_count > cycle_limit);
        $display("timeout after %0d cycles: commit stream stalled with %0d writes still expected",
                 cycle_count, exp_writes.size());
        $display("TB FAILED");
        $finish;
    end

    task automatic rtype(input logic [5:0] fn, input int rd, input int rs, input int rt);
        imem[at] = {op_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
        at++;
    endtask

    task automatic itype(input logic [5:0] op, input int rt, input int rs, input int imm);
        imem[at] = {op, 5'(rs), 5'(rt), 16'(imm)};
        at++;
    endtask

    task automatic jtype(input int target);
        imem[at] = {op_j, 26'(target)};
        at++;
    endtask

    task automatic raw(input logic [31:0] word);
        imem[at] = word;
        at++;
    endtask

    task automatic alu_program();
        itype(op_daddiu, 1, 0, 100);
        itype(op_daddiu, 2, 0, -7);
        rtype(fn_daddu, 3, 1, 2);
        rtype(fn_dsubu, 4, 2, 1);
        rtype(fn_and, 5, 1, 2);
        rtype(fn_or, 6, 1, 2);
        rtype(fn_xor, 7, 1, 2);
        rtype(fn_slt, 8, 2, 1);
        rtype(fn_slt, 9, 1, 2);
        itype(op_lui, 11, 0, 'h8000);
        rtype(fn_slt, 12, 11, 2);
    endtask

    task automatic immediate_program();
        itype(op_daddiu, 1, 0, -32768);
        itype(op_ori, 2, 0, 'h9abc);
        itype(op_ori, 3, 1, 'h00ff);
        itype(op_lui, 4, 0, 'h8000);
        itype(op_lui, 5, 0, 'h1234);
        // r0 destinations
        itype(op_daddiu, 0, 1, 5);
        itype(op_ori, 0, 2, 1);
        rtype(fn_daddu, 0, 1, 2);
        itype(op_daddiu, 6, 5, -1);
    endtask

    task automatic forwarding_program();
        itype(op_daddiu, 1, 0, 3);
        rtype(fn_daddu, 2, 1, 1);
        rtype(fn_daddu, 3, 2, 1);
        rtype(fn_dsubu, 4, 3, 2);
        itype(op_daddiu, 4, 4, 1);
        rtype(fn_xor, 5, 4, 3);
        rtype(fn_or, 6, 5, 4);
        rtype(fn_slt, 7, 6, 5);
        itype(op_daddiu, 8, 0, -1);
        rtype(fn_and, 9, 8, 6);
    endtask

    task automatic branch_program();
        itype(op_daddiu, 1, 0, 5);
        itype(op_daddiu, 2, 0, 5);
        itype(op_beq, 2, 1, 2);
        itype(op_daddiu, 3, 0, 1);
        itype(op_daddiu, 4, 0, 2);
        itype(op_bne, 2, 1, 1);
        itype(op_daddiu, 5, 0, 3);
        itype(op_beq, 1, 5, 1);
        itype(op_daddiu, 6, 0, 6);
        itype(op_bne, 0, 1, 2);
        itype(op_daddiu, 7, 0, 7);
        itype(op_daddiu, 8, 0, 8);
        // count down loop with a backward branch
        itype(op_daddiu, 10, 0, 3);
        itype(op_daddiu, 10, 10, -1);
        itype(op_bne, 0, 10, -2);
        jtype(at + 2);
        itype(op_daddiu, 11, 0, 11);
        itype(op_daddiu, 9, 10, 9);
    endtask

    task automatic reserved_program();
        itype(op_daddiu, 1, 0, 1);
        raw(32'hfc00_0000);
        itype(op_daddiu, 2, 1, 1);
        raw({op_special, 20'd0, 6'h3f});
        itype(op_daddiu, 3, 2, 1);
        raw(32'h8c22_0000);
        itype(op_daddiu, 4, 3, 1);
    endtask

    task automatic load_program(input int num);
        int i;
        // unused words write their own index to r31 if they are ever executed
        for (i = 0; i < 1024; i++) begin
            imem[i] = {op_daddiu, 5'd0, 5'd31, 6'd0, 10'(i)};
        end
        at = 0;
        case (num)
            1: alu_program();
            2: immediate_program();
            3: forwarding_program();
            4: branch_program();
            5: reserved_program();
            default: begin
                forwarding_program();
                branch_program();
            end
        endcase
        // every program parks on a jump to itself
        jtype(at);
    endtask

    // in-order ISA model without a delay slot
    task automatic run_model();
        logic [63:0] regs [0:31];
        logic [63:0] pc;
        logic [63:0] next;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] simm;
        logic [63:0] res;
        logic [31:0] w;
        logic [4:0]  dest;
        logic        write;
        logic        done;
        int          i;
        int          steps;
        for (i = 0; i < 32; i++) begin
            regs[i] = 64'd0;
        end
        pc = reset_pc;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            w = imem[pc[11:2]];
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            simm = {{48{w[15]}}, w[15:0]};
            next = pc + 64'd4;
            dest = w[20:16];
            write = 1'b1;
            res = 64'd0;
            case (w[31:26])
                op_special: begin
                    dest = w[15:11];
                    case (w[5:0])
                        fn_daddu: res = a + b;
                        fn_dsubu: res = a - b;
                        fn_and:   res = a & b;
                        fn_or:    res = a | b;
                        fn_xor:   res = a ^ b;
                        fn_slt:   res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        default: begin
                            write = 1'b0;
                            exp_reserved.push_back(pc);
                        end
                    endcase
                end
                op_daddiu: res = a + simm;
                op_ori:    res = a | {48'd0, w[15:0]};
                op_lui:    res = simm << 16;
                op_beq: begin
                    write = 1'b0;
                    if (a == b) begin
                        next = pc + 64'd4 + (simm << 2);
                    end
                end
                op_bne: begin
                    write = 1'b0;
                    if (a != b) begin
                        next = pc + 64'd4 + (simm << 2);
                    end
                end
                op_j: begin
                    write = 1'b0;
                    next = {pc[63:28], w[25:0], 2'b00};
                    done = (next == pc);
                end
                default: begin
                    write = 1'b0;
                    exp_reserved.push_back(pc);
                end
            endcase
            if (write && dest != 5'd0) begin
                regs[dest] = res;
                exp_writes.push_back({dest, res});
            end
            pc = next;
            steps++;
        end
    endtask

    task automatic run_test(input int num, input string name, input int waits);
        int commits_before;
        int errors_before;
        test_reset = 1'b1;
        max_wait = waits;
        load_program(num);
        exp_writes.delete();
        exp_reserved.delete();
        run_model();
        commits_before = commits;
        errors_before = errors;
        repeat (5) @(posedge clock);
        #1;
        test_reset = 1'b0;
        cycle_count = 0;
        cycle_limit = 40 * at * (waits + 1) + 200;
        while (exp_writes.size() != 0 || exp_reserved.size() != 0) begin
            @(posedge clock);
            cycle_count++;
        end
        // keep spinning on the final jump so stray commits show up
        repeat (20) @(posedge clock);
        #1;
        tests++;
        $display("test %0d %s: %0d commits, %0d errors", num, name,
                 commits - commits_before, errors - errors_before);
    endtask

    initial begin
        test_reset = 1'b1;
        ibus_ack = 1'b0;
        ibus_dat = 32'd0;
        counting = 1'b0;
        max_wait = 0;
        wait_left = 0;
        run_test(1, "r-type alu", 0);
        run_test(2, "immediates and r0", 0);
        run_test(3, "forwarding", 0);
        run_test(4, "branches and jumps", 0);
        run_test(5, "reserved words", 0);
        run_test(6, "random ack waits", 3);
        $display("tests %0d, commits %0d, checks %0d, errors %0d", tests, commits, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/core_pkg.sv
verilog/core_regfile.sv
verilog/core_fetch.sv
verilog/core_decode.sv
verilog/core_execute.sv
verilog/core_top.sv
sim/tb_clock.sv
sim/tb_core.sv

/* verilog/core_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module core_decode (
    input  logic           clock,
    input  logic           reset,
    input  logic           fetch_valid,
    input  core_pkg::inst_t fetch_inst,
    input  logic [63:0]    fetch_pc,
    input  logic           redirect,
    input  logic           wb_valid,
    input  logic [4:0]     wb_regnum,
    input  logic [63:0]    wb_data,
    output logic           id_valid,
    output logic [2:0]     id_alu_op,
    output logic           id_b_imm,
    output logic [63:0]    id_imm,
    output logic [63:0]    id_a_data,
    output logic [63:0]    id_b_data,
    output logic [4:0]     id_rs,
    output logic [4:0]     id_rt,
    output logic [4:0]     id_wregnum,
    output logic           id_write_enable,
    output logic           id_beq,
    output logic           id_bne,
    output logic           id_jump,
    output logic [63:0]    id_branch_target,
    output logic [63:0]    id_jump_target,
    output logic           id_reserved,
    output logic [63:0]    id_pc
);
    import core_pkg::*;

    logic [2:0]  alu_op;
    logic        b_imm;
    logic [63:0] imm;
    logic [4:0]  wregnum;
    logic        write_enable;
    logic        beq;
    logic        bne;
    logic        jump;
    logic        reserved;
    logic        take;
    logic [63:0] rf_a_data;
    logic [63:0] rf_b_data;
    logic [63:0] a_data;
    logic [63:0] b_data;
    logic [63:0] branch_target;
    logic [63:0] jump_target;

    core_regfile u_regfile (
        .clock       (clock),
        .reset       (reset),
        .read_a_num  (fetch_inst.i.rs),
        .read_b_num  (fetch_inst.i.rt),
        .write_enable(wb_valid),
        .write_num   (wb_regnum),
        .write_data  (wb_data),
        .read_a_data (rf_a_data),
        .read_b_data (rf_b_data)
    );

    always_comb begin
        alu_op = alu_add;
        b_imm = 1'b1;
        write_enable = 1'b1;
        wregnum = fetch_inst.i.rt;
        beq = 1'b0;
        bne = 1'b0;
        jump = 1'b0;
        reserved = 1'b0;
        case (fetch_inst.r.op)
            op_special: begin
                b_imm = 1'b0;
                wregnum = fetch_inst.r.rd;
                case (fetch_inst.r.funct)
                    fn_daddu: alu_op = alu_add;
                    fn_dsubu: alu_op = alu_sub;
                    fn_and:   alu_op = alu_and;
                    fn_or:    alu_op = alu_or;
                    fn_xor:   alu_op = alu_xor;
                    fn_slt:   alu_op = alu_slt;
                    default:  reserved = 1'b1;
                endcase
            end
            op_daddiu: alu_op = alu_add;
            op_ori:    alu_op = alu_or;
            op_lui:    alu_op = alu_lui;
            op_beq: begin
                beq = 1'b1;
                b_imm = 1'b0;
                write_enable = 1'b0;
            end
            op_bne: begin
                bne = 1'b1;
                b_imm = 1'b0;
                write_enable = 1'b0;
            end
            op_j: begin
                jump = 1'b1;
                write_enable = 1'b0;
            end
            default: reserved = 1'b1;
        endcase
        // r0 writes are dropped here
        if (reserved || wregnum == 5'd0) begin
            write_enable = 1'b0;
        end

        case (fetch_inst.i.op)
            op_ori:  imm = {48'd0, fetch_inst.i.imm};
            op_lui:  imm = {{32{fetch_inst.i.imm[15]}}, fetch_inst.i.imm, 16'd0};
            default: imm = {{48{fetch_inst.i.imm[15]}}, fetch_inst.i.imm};
        endcase
    end

    // no delay slot, so targets are relative to this instruction
    assign branch_target = fetch_pc + 64'd4 + {{46{fetch_inst.i.imm[15]}}, fetch_inst.i.imm, 2'b00};
    assign jump_target = {fetch_pc[63:28], fetch_inst.i.rs, fetch_inst.i.rt, fetch_inst.i.imm, 2'b00};

    // value being written back this cycle is not in the regfile yet
    assign a_data = (wb_valid && wb_regnum == fetch_inst.i.rs) ? wb_data : rf_a_data;
    assign b_data = (wb_valid && wb_regnum == fetch_inst.i.rt) ? wb_data : rf_b_data;

    assign take = fetch_valid && !redirect;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
            id_write_enable <= 1'b0;
            id_beq <= 1'b0;
            id_bne <= 1'b0;
            id_jump <= 1'b0;
            id_reserved <= 1'b0;
        end else begin
            // bubble on redirect or empty fetch
            id_valid <= take;
            id_write_enable <= take && write_enable;
            id_beq <= take && beq;
            id_bne <= take && bne;
            id_jump <= take && jump;
            id_reserved <= take && reserved;
        end
    end

    always_ff @(posedge clock) begin
        id_alu_op <= alu_op;
        id_b_imm <= b_imm;
        id_imm <= imm;
        id_a_data <= a_data;
        id_b_data <= b_data;
        id_rs <= fetch_inst.i.rs;
        id_rt <= fetch_inst.i.rt;
        id_wregnum <= wregnum;
        id_branch_target <= branch_target;
        id_jump_target <= jump_target;
        id_pc <= fetch_pc;
    end

endmodule

`default_nettype wire

/* verilog/core_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module core_execute (
    input  logic        clock,
    input  logic        reset,
    input  logic        id_valid,
    input  logic [2:0]  id_alu_op,
    input  logic        id_b_imm,
    input  logic [63:0] id_imm,
    input  logic [63:0] id_a_data,
    input  logic [63:0] id_b_data,
    input  logic [4:0]  id_rs,
    input  logic [4:0]  id_rt,
    input  logic [4:0]  id_wregnum,
    input  logic        id_write_enable,
    input  logic        id_beq,
    input  logic        id_bne,
    input  logic        id_jump,
    input  logic [63:0] id_branch_target,
    input  logic [63:0] id_jump_target,
    input  logic        id_reserved,
    input  logic [63:0] id_pc,
    output logic        wb_valid,
    output logic [4:0]  wb_regnum,
    output logic [63:0] wb_data,
    output logic        redirect,
    output logic [63:0] redirect_pc,
    output logic        reserved_inst,
    output logic [63:0] reserved_pc
);
    import core_pkg::*;

    logic [63:0] a;
    logic [63:0] b_reg;
    logic [63:0] b;
    logic [63:0] result;
    logic        equal;
    logic        taken;

    // distance 1 forwarding from the previous result
    assign a = (wb_valid && wb_regnum == id_rs) ? wb_data : id_a_data;
    assign b_reg = (wb_valid && wb_regnum == id_rt) ? wb_data : id_b_data;
    assign b = id_b_imm ? id_imm : b_reg;

    always_comb begin
        case (id_alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {63'd0, $signed(a) < $signed(b)};
            alu_lui: result = b;
            default: result = 64'd0;
        endcase
    end

    assign equal = (a == b_reg);
    assign taken = (id_beq && equal) || (id_bne && !equal);
    assign redirect = id_valid && (taken || id_jump);
    assign redirect_pc = id_jump ? id_jump_target : id_branch_target;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
            reserved_inst <= 1'b0;
        end else begin
            wb_valid <= id_valid && id_write_enable;
            reserved_inst <= id_valid && id_reserved;
        end
    end

    always_ff @(posedge clock) begin
        wb_regnum <= id_wregnum;
        wb_data <= result;
        reserved_pc <= id_pc;
    end

endmodule

`default_nettype wire

/* verilog/core_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module core_fetch (
    input  logic        clock,
    input  logic        reset,
    input  logic        redirect,
    input  logic [63:0] redirect_pc,
    input  logic        ibus_ack,
    input  logic [31:0] ibus_dat,
    output logic        ibus_cyc,
    output logic        ibus_stb,
    output logic [63:0] ibus_adr,
    output logic        fetch_valid,
    output logic [31:0] fetch_inst,
    output logic [63:0] fetch_pc
);
    import core_pkg::*;

    logic [63:0] pc;
    logic [63:0] pc_next;
    logic        discard;
    logic        capture;

    assign ibus_stb = ibus_cyc;
    assign capture = ibus_cyc && ibus_ack;

    // decode takes a valid entry at every edge, so fetch_valid means consumed
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (fetch_valid) begin
            pc_next = pc + 64'd4;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
            ibus_cyc <= 1'b0;
            discard <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (ibus_cyc) begin
                if (ibus_ack) begin
                    ibus_cyc <= 1'b0;
                    discard <= 1'b0;
                    // stale word from before a redirect never becomes valid
                    fetch_valid <= !(discard || redirect);
                end else if (redirect) begin
                    discard <= 1'b1;
                end
            end else begin
                // entry consumed or bus idle, open the next read
                fetch_valid <= 1'b0;
                ibus_cyc <= 1'b1;
            end
        end
    end

    // address is fixed for the whole bus cycle
    always_ff @(posedge clock) begin
        if (!ibus_cyc) begin
            ibus_adr <= pc_next;
        end
        if (capture) begin
            fetch_inst <= ibus_dat;
            fetch_pc <= ibus_adr;
        end
    end

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    // major opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_daddiu  = 6'h19;

    // SPECIAL function codes
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_slt     = 6'h2a;
    localparam logic [5:0] fn_daddu   = 6'h2d;
    localparam logic [5:0] fn_dsubu   = 6'h2f;

    // ALU operations
    localparam logic [2:0] alu_add    = 3'd0;
    localparam logic [2:0] alu_sub    = 3'd1;
    localparam logic [2:0] alu_and    = 3'd2;
    localparam logic [2:0] alu_or     = 3'd3;
    localparam logic [2:0] alu_xor    = 3'd4;
    localparam logic [2:0] alu_slt    = 3'd5;
    localparam logic [2:0] alu_lui    = 3'd6;

    localparam logic [63:0] reset_pc  = 64'h0000_0000_0000_0000;

    // one instruction word, read as register fields or as immediate fields
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } inst_t;

endpackage

`default_nettype wire

/* verilog/core_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module core_regfile (
    input  logic        clock,
    input  logic        reset,
    input  logic [4:0]  read_a_num,
    input  logic [4:0]  read_b_num,
    input  logic        write_enable,
    input  logic [4:0]  write_num,
    input  logic [63:0] write_data,
    output logic [63:0] read_a_data,
    output logic [63:0] read_b_data
);
    logic [63:0] regs [31:1];

    // register zero is not stored
    assign read_a_data = (read_a_num == 5'd0) ? 64'd0 : regs[read_a_num];
    assign read_b_data = (read_b_num == 5'd0) ? 64'd0 : regs[read_b_num];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 64'd0;
            end
        end else if (write_enable && write_num != 5'd0) begin
            regs[write_num] <= write_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic        clock,
    input  logic        reset,
    output logic        ibus_cyc,
    output logic        ibus_stb,
    output logic [63:0] ibus_adr,
    input  logic        ibus_ack,
    input  logic [31:0] ibus_dat,
    output logic        wb_valid,
    output logic [4:0]  wb_regnum,
    output logic [63:0] wb_data,
    output logic        reserved_inst,
    output logic [63:0] reserved_pc
);
    logic        fetch_valid;
    logic [31:0] fetch_inst;
    logic [63:0] fetch_pc;
    logic        redirect;
    logic [63:0] redirect_pc;
    logic        id_valid;
    logic [2:0]  id_alu_op;
    logic        id_b_imm;
    logic [63:0] id_imm;
    logic [63:0] id_a_data;
    logic [63:0] id_b_data;
    logic [4:0]  id_rs;
    logic [4:0]  id_rt;
    logic [4:0]  id_wregnum;
    logic        id_write_enable;
    logic        id_beq;
    logic        id_bne;
    logic        id_jump;
    logic [63:0] id_branch_target;
    logic [63:0] id_jump_target;
    logic        id_reserved;
    logic [63:0] id_pc;

    core_fetch u_fetch (
        .clock      (clock),
        .reset      (reset),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .ibus_ack   (ibus_ack),
        .ibus_dat   (ibus_dat),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .fetch_valid(fetch_valid),
        .fetch_inst (fetch_inst),
        .fetch_pc   (fetch_pc)
    );

    core_decode u_decode (
        .clock           (clock),
        .reset           (reset),
        .fetch_valid     (fetch_valid),
        .fetch_inst      (fetch_inst),
        .fetch_pc        (fetch_pc),
        .redirect        (redirect),
        .wb_valid        (wb_valid),
        .wb_regnum       (wb_regnum),
        .wb_data         (wb_data),
        .id_valid        (id_valid),
        .id_alu_op       (id_alu_op),
        .id_b_imm        (id_b_imm),
        .id_imm          (id_imm),
        .id_a_data       (id_a_data),
        .id_b_data       (id_b_data),
        .id_rs           (id_rs),
        .id_rt           (id_rt),
        .id_wregnum      (id_wregnum),
        .id_write_enable (id_write_enable),
        .id_beq          (id_beq),
        .id_bne          (id_bne),
        .id_jump         (id_jump),
        .id_branch_target(id_branch_target),
        .id_jump_target  (id_jump_target),
        .id_reserved     (id_reserved),
        .id_pc           (id_pc)
    );

    core_execute u_execute (
        .clock           (clock),
        .reset           (reset),
        .id_valid        (id_valid),
        .id_alu_op       (id_alu_op),
        .id_b_imm        (id_b_imm),
        .id_imm          (id_imm),
        .id_a_data       (id_a_data),
        .id_b_data       (id_b_data),
        .id_rs           (id_rs),
        .id_rt           (id_rt),
        .id_wregnum      (id_wregnum),
        .id_write_enable (id_write_enable),
        .id_beq          (id_beq),
        .id_bne          (id_bne),
        .id_jump         (id_jump),
        .id_branch_target(id_branch_target),
        .id_jump_target  (id_jump_target),
        .id_reserved     (id_reserved),
        .id_pc           (id_pc),
        .wb_valid        (wb_valid),
        .wb_regnum       (wb_regnum),
        .wb_data         (wb_data),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .reserved_inst   (reserved_inst),
        .reserved_pc     (reserved_pc)
    );

endmodule

`default_nettype wire
